/* corr_cfg_pkg.sv */
`default_nettype none

package corr_cfg_pkg;

   // --------------------------------------------------
   // Array sizes
   // --------------------------------------------------
   localparam int NUM_ANT   = 4;            // Antennas, one 1-bit sample each
   localparam int NUM_PAIRS = 6;            // NUM_ANT*(NUM_ANT-1)/2
   localparam int NUM_VIS   = 2 * NUM_PAIRS; // Real and imaginary per pair

   // Accumulator and bus data width
   localparam int ACC_W     = 16;
   localparam int VIS_IDX_W = $clog2(NUM_VIS); // 4 bits, room for 0..15

   // Bank counter width, free running
   localparam int BANK_W    = 16;

   // Block length minus 1 after reset
   localparam logic [ACC_W-1:0] DEFAULT_BLOCKSIZE = 16'd15;

   // --------------------------------------------------
   // Antenna pair table
   // --------------------------------------------------
   // Pair p correlates antenna PAIR_A[p] with PAIR_B[p]
   // Order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
   localparam int PAIR_A [NUM_PAIRS] = '{0, 0, 0, 1, 1, 2};
   localparam int PAIR_B [NUM_PAIRS] = '{1, 2, 3, 2, 3, 3};

   // Visibility word = 2*pair + 0 real / 1 imaginary
   localparam int VIS_RE = 0;
   localparam int VIS_IM = 1;

endpackage

`default_nettype wire

/* corr_bus_pkg.sv */
`default_nettype none

package corr_bus_pkg;

   // --------------------------------------------------
   // Address map
   // --------------------------------------------------
   localparam int ADR_W   = 6;
   localparam int DEV_LSB = 4;   // adr_i[5:4] picks the device

   // Device selector
   typedef enum logic [1:0] {
      DEV_VIS   = 2'd0,   // Visibility readout, read only
      DEV_SYS   = 2'd1,   // System registers
      DEV_NONE2 = 2'd2,   // Unmapped
      DEV_NONE3 = 2'd3    // Unmapped
   } dev_e;

   // System register index, adr_i[1:0]
   typedef enum logic [1:0] {
      REG_BLOCKSIZE = 2'd0,   // Block length minus 1
      REG_CONTROL   = 2'd1,   // Bit 0 enable
      REG_BANKCOUNT = 2'd2,   // Completed blocks, read only
      REG_RSVD      = 2'd3    // Reads as 0
   } sys_reg_e;

endpackage

`default_nettype wire

/* corr_quadrature.sv */
`timescale 1ns/1ps
`default_nettype none

// Fake Hilbert stage for 1-bit data
// Imaginary part of each antenna is its previous sample
module corr_quadrature
   import corr_cfg_pkg::*;
(
   input  wire                 clk_i,
   input  wire                 rst,
   input  wire                 enable_i,
   input  wire                 sample_stb_i,
   input  wire [NUM_ANT-1:0]   antenna_i,
   output logic                valid_o,
   output logic [NUM_ANT-1:0]  re_o,
   output logic [NUM_ANT-1:0]  im_o
);

   // Sample accepted only while acquisition is enabled
   logic take;

   assign take = sample_stb_i & enable_i;

   // --------------------------------------------------
   // Current and previous sample vectors
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst) begin
         valid_o <= 1'b0;
         re_o    <= '0;   // History starts at zero
      end else begin
         valid_o <= take;   // One cycle pulse per accepted sample
         if (take) begin
            re_o <= antenna_i;
         end
      end
   end

   // Delayed copy, follows re_o only on accepted samples
   always_ff @(posedge clk_i) begin
      if (rst) begin
         im_o <= '0;
      end else if (take) begin
         im_o <= re_o;   // Previous sample becomes the quadrature part
      end
   end

endmodule

`default_nettype wire

/* corr_bank_switch.sv */
`timescale 1ns/1ps
`default_nettype none

// Block length counter and bank swap pulse
module corr_bank_switch
   import corr_cfg_pkg::*;
(
   input  wire                clk_i,
   input  wire                rst,
   input  wire                valid_i,
   input  wire  [ACC_W-1:0]   blocksize_i,
   output logic               swap_o,
   output logic [BANK_W-1:0]  bank_count_o
);

   logic [ACC_W-1:0] sample_cnt;   // Samples seen in this block
   logic             last_sample;

   // --------------------------------------------------
   // End of block detect
   // --------------------------------------------------
   // Greater-or-equal so a block size lowered mid-block
   // ends the block at once instead of wrapping the count
   assign last_sample = (sample_cnt >= blocksize_i);

   // Same cycle as the valid carrying the last sample
   assign swap_o = valid_i & last_sample;

   always_ff @(posedge clk_i) begin
      if (rst) begin
         sample_cnt <= '0;
      end else if (valid_i) begin
         if (last_sample) begin
            sample_cnt <= '0;   // Next block starts
         end else begin
            sample_cnt <= sample_cnt + 1'b1;
         end
      end
   end

   // --------------------------------------------------
   // Completed block counter
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst) begin
         bank_count_o <= '0;
      end else if (swap_o) begin
         bank_count_o <= bank_count_o + 1'b1;   // Wraps freely
      end
   end

endmodule

`default_nettype wire

/* corr_block.sv */
`timescale 1ns/1ps
`default_nettype none

// Visibility accumulators for all antenna pairs
// plus the readout bank that the bus reads from
module corr_block
   import corr_cfg_pkg::*;
(
   input  wire                   clk_i,
   input  wire                   rst,
   input  wire                   valid_i,
   input  wire                   swap_i,
   input  wire  [NUM_ANT-1:0]    re_i,
   input  wire  [NUM_ANT-1:0]    im_i,
   input  wire                   rd_stb_i,
   input  wire  [VIS_IDX_W-1:0]  rd_idx_i,
   output logic [ACC_W-1:0]      rd_dat_o
);

   logic [ACC_W-1:0] acc  [NUM_VIS];   // Running sums
   logic [ACC_W-1:0] bank [NUM_VIS];   // Totals of the last block
   logic [NUM_VIS-1:0] hit;            // Per word increment

   // --------------------------------------------------
   // 1-bit correlation
   // --------------------------------------------------
   // Equal signs count as +1, XNOR of the two bits
   always_comb begin
      for (int p = 0; p < NUM_PAIRS; p++) begin
         hit[2*p + VIS_RE] = ~(re_i[PAIR_A[p]] ^ re_i[PAIR_B[p]]);
         hit[2*p + VIS_IM] = ~(re_i[PAIR_A[p]] ^ im_i[PAIR_B[p]]);
      end
   end

   // --------------------------------------------------
   // Accumulate and swap
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst) begin
         for (int k = 0; k < NUM_VIS; k++) begin
            acc[k]  <= '0;
            bank[k] <= '0;
         end
      end else if (valid_i) begin
         for (int k = 0; k < NUM_VIS; k++) begin
            if (swap_i) begin
               bank[k] <= acc[k] + ACC_W'(hit[k]);   // Last sample included
               acc[k]  <= '0;                        // Restart from zero
            end else begin
               acc[k]  <= acc[k] + ACC_W'(hit[k]);
            end
         end
      end
   end

   // --------------------------------------------------
   // Readout port
   // --------------------------------------------------
   // Index range already checked by the bus decoder
   always_ff @(posedge clk_i) begin
      if (rd_stb_i) begin
         rd_dat_o <= bank[rd_idx_i];   // Valid on the ack cycle
      end
   end

endmodule

`default_nettype wire

/* corr_regs.sv */
`timescale 1ns/1ps
`default_nettype none

// System register bank
module corr_regs
   import corr_cfg_pkg::*;
   import corr_bus_pkg::*;
(
   input  wire                clk_i,
   input  wire                rst,
   input  wire                stb_i,
   input  wire                we_i,
   input  sys_reg_e           idx_i,
   input  wire  [ACC_W-1:0]   wdat_i,
   input  wire  [BANK_W-1:0]  bank_count_i,
   output logic [ACC_W-1:0]   rdat_o,
   output logic [ACC_W-1:0]   blocksize_o,
   output logic               enable_o
);

   // --------------------------------------------------
   // Writes
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst) begin
         blocksize_o <= DEFAULT_BLOCKSIZE;
         enable_o    <= 1'b0;   // Acquisition off after reset
      end else if (stb_i && we_i) begin
         case (idx_i)
            REG_BLOCKSIZE: blocksize_o <= wdat_i;
            REG_CONTROL:   enable_o    <= wdat_i[0];
            default: ;   // Read only, decoder flags these
         endcase
      end
   end

   // --------------------------------------------------
   // Reads, one cycle like the visibility port
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (stb_i && !we_i) begin
         case (idx_i)
            REG_BLOCKSIZE: rdat_o <= blocksize_o;
            REG_CONTROL:   rdat_o <= {{(ACC_W-1){1'b0}}, enable_o};
            REG_BANKCOUNT: rdat_o <= ACC_W'(bank_count_i);
            default:       rdat_o <= '0;   // Reserved
         endcase
      end
   end

endmodule

`default_nettype wire

/* corr_bus_decode.sv */
`timescale 1ns/1ps
`default_nettype none

// Address decoder, error checks and reply path
module corr_bus_decode
   import corr_cfg_pkg::*;
   import corr_bus_pkg::*;
(
   input  wire                   clk_i,
   input  wire                   rst,
   input  wire                   stb_i,
   input  wire                   we_i,
   input  wire  [ADR_W-1:0]      adr_i,
   input  wire  [ACC_W-1:0]      dat_i,
   input  wire  [ACC_W-1:0]      vis_rdat_i,
   input  wire  [ACC_W-1:0]      sys_rdat_i,
   output logic                  ack_o,
   output logic                  err_o,
   output logic [ACC_W-1:0]      dat_o,
   output logic                  vis_stb_o,
   output logic [VIS_IDX_W-1:0]  vis_idx_o,
   output logic                  sys_stb_o,
   output logic                  sys_we_o,
   output sys_reg_e              sys_idx_o,
   output logic [ACC_W-1:0]      sys_wdat_o
);

   dev_e dev;       // Device of the current request
   logic bad;       // Request breaks the map rules
   logic sel_vis;   // Remembered device for the reply

   // --------------------------------------------------
   // Address fields
   // --------------------------------------------------
   assign dev        = dev_e'(adr_i[DEV_LSB +: 2]);
   assign vis_idx_o  = adr_i[VIS_IDX_W-1:0];
   assign sys_idx_o  = sys_reg_e'(adr_i[1:0]);
   assign sys_we_o   = we_i;
   assign sys_wdat_o = dat_i;

   // Error rules
   always_comb begin
      case (dev)
         DEV_VIS: bad = we_i || (vis_idx_o >= VIS_IDX_W'(NUM_VIS));   // Read only
         DEV_SYS: bad = we_i && (sys_idx_o == REG_BANKCOUNT ||
                                 sys_idx_o == REG_RSVD);
         default: bad = 1'b1;   // Unmapped space
      endcase
   end

   // Device strobes, only for legal requests
   assign vis_stb_o = stb_i && !bad && (dev == DEV_VIS);
   assign sys_stb_o = stb_i && !bad && (dev == DEV_SYS);

   // --------------------------------------------------
   // Reply one cycle later
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst) begin
         ack_o <= 1'b0;
         err_o <= 1'b0;
      end else begin
         ack_o <= stb_i && !bad;
         err_o <= stb_i && bad;   // Never together with ack
      end
   end

   always_ff @(posedge clk_i) begin
      if (stb_i) begin
         sel_vis <= (dev == DEV_VIS);
      end
   end

   // Devices hold their read word, pick the one addressed
   assign dat_o = sel_vis ? vis_rdat_i : sys_rdat_i;

endmodule

`default_nettype wire

/* corr_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Correlator top level
module corr_top
   import corr_cfg_pkg::*;
   import corr_bus_pkg::*;
(
   input  wire                clk_i,
   input  wire                rst,
   // Bus
   input  wire                stb_i,
   input  wire                we_i,
   input  wire  [ADR_W-1:0]   adr_i,
   input  wire  [ACC_W-1:0]   dat_i,
   output logic               ack_o,
   output logic               err_o,
   output logic [ACC_W-1:0]   dat_o,
   // Samples
   input  wire                sample_stb_i,
   input  wire  [NUM_ANT-1:0] antenna_i,
   // Status
   output logic               swap_o,
   output logic [1:0]         bank_o
);

   logic                 vis_stb;
   logic [VIS_IDX_W-1:0] vis_idx;
   logic [ACC_W-1:0]     vis_rdat;
   logic                 sys_stb;
   logic                 sys_we;
   sys_reg_e             sys_idx;
   logic [ACC_W-1:0]     sys_wdat;
   logic [ACC_W-1:0]     sys_rdat;
   logic [ACC_W-1:0]     blocksize;
   logic                 enable;
   logic                 valid;
   logic [NUM_ANT-1:0]   re;
   logic [NUM_ANT-1:0]   im;
   logic                 swap;
   logic [BANK_W-1:0]    bank_count;

   assign swap_o = swap;
   assign bank_o = bank_count[1:0];   // Low bits only

   // --------------------------------------------------
   // Bus side
   // --------------------------------------------------
   corr_bus_decode i_bus_decode (
      .clk_i      (clk_i),
      .rst        (rst),
      .stb_i      (stb_i),
      .we_i       (we_i),
      .adr_i      (adr_i),
      .dat_i      (dat_i),
      .vis_rdat_i (vis_rdat),
      .sys_rdat_i (sys_rdat),
      .ack_o      (ack_o),
      .err_o      (err_o),
      .dat_o      (dat_o),
      .vis_stb_o  (vis_stb),
      .vis_idx_o  (vis_idx),
      .sys_stb_o  (sys_stb),
      .sys_we_o   (sys_we),
      .sys_idx_o  (sys_idx),
      .sys_wdat_o (sys_wdat)
   );

   corr_regs i_regs (
      .clk_i        (clk_i),
      .rst          (rst),
      .stb_i        (sys_stb),
      .we_i         (sys_we),
      .idx_i        (sys_idx),
      .wdat_i       (sys_wdat),
      .bank_count_i (bank_count),
      .rdat_o       (sys_rdat),
      .blocksize_o  (blocksize),
      .enable_o     (enable)
   );

   // --------------------------------------------------
   // Sample path
   // --------------------------------------------------
   corr_quadrature i_quadrature (
      .clk_i        (clk_i),
      .rst          (rst),
      .enable_i     (enable),
      .sample_stb_i (sample_stb_i),
      .antenna_i    (antenna_i),
      .valid_o      (valid),
      .re_o         (re),
      .im_o         (im)
   );

   corr_bank_switch i_bank_switch (
      .clk_i        (clk_i),
      .rst          (rst),
      .valid_i      (valid),
      .blocksize_i  (blocksize),
      .swap_o       (swap),
      .bank_count_o (bank_count)
   );

   corr_block i_block (
      .clk_i    (clk_i),
      .rst      (rst),
      .valid_i  (valid),
      .swap_i   (swap),
      .re_i     (re),
      .im_i     (im),
      .rd_stb_i (vis_stb),
      .rd_idx_i (vis_idx),
      .rd_dat_o (vis_rdat)
   );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// Free running testbench clock
module tb_clock_gen #(
   parameter real PERIOD_NS = 4.0
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;   // Toggle every half period
   end

endmodule

`default_nettype wire

/* tb_corr_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_corr_top
   import corr_cfg_pkg::*;
   import corr_bus_pkg::*;
();

   localparam int BUS_TIMEOUT  = 10;   // Cycles to wait for ack or err
   localparam int SWAP_TIMEOUT = 20;   // Cycles to wait for swap_o
   localparam int NUM_ROWS     = 12;

   // Addresses built from the map
   localparam logic [ADR_W-1:0] ADR_BLOCKSIZE = {DEV_SYS, 2'b00, REG_BLOCKSIZE};
   localparam logic [ADR_W-1:0] ADR_CONTROL   = {DEV_SYS, 2'b00, REG_CONTROL};
   localparam logic [ADR_W-1:0] ADR_BANKCOUNT = {DEV_SYS, 2'b00, REG_BANKCOUNT};
   localparam logic [ADR_W-1:0] ADR_RSVD      = {DEV_SYS, 2'b00, REG_RSVD};
   localparam logic [ADR_W-1:0] ADR_NONE2     = {DEV_NONE2, 4'h0};

   typedef enum logic [1:0] {K_REG, K_BLOCK, K_ERR} kind_e;

   typedef struct packed {
      kind_e       kind;
      logic        we;
      logic [5:0]  adr;
      logic [15:0] data;    // Write value or block size
      logic        en;      // Enable bit for block rows
      logic [7:0]  nsamp;
      logic [15:0] expv;    // Read value, or 1 when a swap is due
   } row_t;

   // --------------------------------------------------
   // Stimulus table
   // --------------------------------------------------
   localparam row_t ROWS [NUM_ROWS] = '{
      '{K_REG,   1'b1, ADR_BLOCKSIZE, 16'd9, 1'b0, 8'd0,  16'd9},
      '{K_REG,   1'b1, ADR_CONTROL,   16'd1, 1'b0, 8'd0,  16'd1},
      '{K_REG,   1'b0, ADR_RSVD,      16'd0, 1'b0, 8'd0,  16'd0},
      '{K_BLOCK, 1'b0, 6'h00,         16'd9, 1'b1, 8'd10, 16'd1},   // First block
      '{K_BLOCK, 1'b0, 6'h00,         16'd5, 1'b1, 8'd6,  16'd1},   // Back to back
      '{K_ERR,   1'b0, ADR_NONE2,     16'd0, 1'b0, 8'd0,  16'd0},
      '{K_ERR,   1'b1, 6'h00,         16'd0, 1'b0, 8'd0,  16'd0},   // Write to DEV_VIS
      '{K_ERR,   1'b0, 6'h0d,         16'd0, 1'b0, 8'd0,  16'd0},   // Index 13
      '{K_ERR,   1'b1, ADR_BANKCOUNT, 16'd0, 1'b0, 8'd0,  16'd0},
      '{K_BLOCK, 1'b0, 6'h00,         16'd7, 1'b1, 8'd3,  16'd0},   // Part of a block
      '{K_BLOCK, 1'b0, 6'h00,         16'd7, 1'b0, 8'd5,  16'd0},   // Enable clear
      '{K_BLOCK, 1'b0, 6'h00,         16'd7, 1'b1, 8'd5,  16'd1}    // Rest of block
   };

   logic clk;
   logic rst;
   logic stb;
   logic we;
   logic [ADR_W-1:0] adr;
   logic [ACC_W-1:0] wdat;
   logic ack;
   logic err;
   logic [ACC_W-1:0] rdat;
   logic sample_stb;
   logic [NUM_ANT-1:0] antenna;
   logic swap;
   logic [1:0] bank;

   logic [15:0] lfsr_state;
   logic [15:0] exp_banks;
   logic [NUM_ANT-1:0] model_prev;   // Last accepted sample
   int model_acc [NUM_VIS];
   int model_tot [NUM_VIS];
   int errors;
   int checks;
   int err_before;

   tb_clock_gen i_clock_gen (.clk_o(clk));

   corr_top i_corr_top (
      .clk_i        (clk),
      .rst          (rst),
      .stb_i        (stb),
      .we_i         (we),
      .adr_i        (adr),
      .dat_i        (wdat),
      .ack_o        (ack),
      .err_o        (err),
      .dat_o        (rdat),
      .sample_stb_i (sample_stb),
      .antenna_i    (antenna),
      .swap_o       (swap),
      .bank_o       (bank)
   );

   // 16-bit Galois LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
   endfunction

   function automatic string row_label(input kind_e k);
      case (k)
         K_REG:   return "register";
         K_BLOCK: return "block";
         default: return "error";
      endcase
   endfunction

   // --------------------------------------------------
   // Reference model
   // --------------------------------------------------
   task automatic model_update(input logic [NUM_ANT-1:0] cur);
      int p;
      p = 0;
      for (int a = 0; a < NUM_ANT; a++) begin   // Pairs a<b, table order
         for (int b = a + 1; b < NUM_ANT; b++) begin
            if (cur[a] == cur[b])
               model_acc[2*p]++;              // Real part
            if (cur[a] == model_prev[b])
               model_acc[2*p + 1]++;          // Against delayed sample
            p++;
         end
      end
      model_prev = cur;
   endtask

   // --------------------------------------------------
   // Bus and sample tasks
   // --------------------------------------------------
   task automatic bus_access(input logic w, input logic [ADR_W-1:0] a,
                             input logic [ACC_W-1:0] wd, output logic [ACC_W-1:0] rd,
                             output logic got_ack, output logic got_err);
      int waited;
      @(posedge clk);
      #1;
      stb  = 1'b1;
      we   = w;
      adr  = a;
      wdat = wd;
      @(posedge clk);
      #1;
      stb = 1'b0;
      we  = 1'b0;
      waited = 0;
      while (!ack && !err && waited < BUS_TIMEOUT) begin
         @(posedge clk);
         #1;
         waited++;
      end
      got_ack = ack;
      got_err = err;
      rd      = rdat;
      if (!ack && !err) begin
         $display("No bus reply from address 0x%h within %0d cycles", a, BUS_TIMEOUT);
         errors++;
      end
   endtask

   task automatic bus_write(input logic [ADR_W-1:0] a, input logic [ACC_W-1:0] wd);
      logic [ACC_W-1:0] d;
      logic ga;
      logic ge;
      bus_access(1'b1, a, wd, d, ga, ge);
      if (!ga || ge) begin
         $display("Write to address 0x%h was not acknowledged", a);
         errors++;
      end
   endtask

   task automatic bus_read(input logic [ADR_W-1:0] a, output logic [ACC_W-1:0] d);
      logic ga;
      logic ge;
      bus_access(1'b0, a, '0, d, ga, ge);
      if (!ga || ge) begin
         $display("Read of address 0x%h was not acknowledged", a);
         errors++;
      end
   endtask

   // One sample per cycle, 4 LFSR bits each
   task automatic send_samples(input int n, input logic en);
      logic [NUM_ANT-1:0] cur;
      for (int s = 0; s < n; s++) begin
         for (int b = 0; b < NUM_ANT; b++) begin
            cur[b]     = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
         end
         @(posedge clk);
         #1;
         sample_stb = 1'b1;
         antenna    = cur;
         if (en)
            model_update(cur);   // DUT drops samples while disabled
      end
      @(posedge clk);
      #1;
      sample_stb = 1'b0;
   endtask

   task automatic wait_swap(input int limit, output logic found);
      int waited;
      waited = 0;
      while (!swap && waited < limit) begin
         @(posedge clk);
         #1;
         waited++;
      end
      found = swap;
   endtask

   // --------------------------------------------------
   // One table row
   // --------------------------------------------------
   task automatic run_row(input row_t row);
      logic [ACC_W-1:0] d;
      logic ga;
      logic ge;
      logic found;
      case (row.kind)
         K_REG: begin
            if (row.we)
               bus_write(row.adr, row.data);
            bus_read(row.adr, d);
            checks++;
            if (d !== row.expv) begin
               $display("CHECK FAILED dat_o got 0x%h expected 0x%h", d, row.expv);
               errors++;
            end
         end
         K_ERR: begin
            bus_access(row.we, row.adr, '0, d, ga, ge);
            checks += 2;
            if (ge !== 1'b1) begin
               $display("CHECK FAILED err_o got 0x%h expected 0x1", ge);
               errors++;
            end
            if (ga !== 1'b0) begin
               $display("CHECK FAILED ack_o got 0x%h expected 0x0", ga);
               errors++;
            end
         end
         default: begin
            bus_write(ADR_BLOCKSIZE, row.data);
            bus_write(ADR_CONTROL, {15'd0, row.en});
            send_samples(int'(row.nsamp), row.en);
            wait_swap(SWAP_TIMEOUT, found);
            checks++;
            if (row.expv[0] && !found) begin
               $display("swap_o did not rise within %0d cycles", SWAP_TIMEOUT);
               errors++;
            end else if (!row.expv[0] && found) begin
               $display("swap_o rose although the block was not complete");
               errors++;
            end
            if (row.expv[0]) begin
               exp_banks++;
               for (int k = 0; k < NUM_VIS; k++) begin   // Bank handoff
                  model_tot[k] = model_acc[k];
                  model_acc[k] = 0;
               end
               for (int k = 0; k < NUM_VIS; k++) begin
                  bus_read(ADR_W'(k), d);
                  checks++;
                  if (d !== ACC_W'(model_tot[k])) begin
                     $display("CHECK FAILED vis[%0d] dat_o got 0x%h expected 0x%h",
                              k, d, ACC_W'(model_tot[k]));
                     errors++;
                  end
               end
            end
            bus_read(ADR_BANKCOUNT, d);
            checks += 2;
            if (d !== exp_banks) begin
               $display("CHECK FAILED bank_count got 0x%h expected 0x%h", d, exp_banks);
               errors++;
            end
            if (bank !== exp_banks[1:0]) begin
               $display("CHECK FAILED bank_o got 0x%h expected 0x%h", bank, exp_banks[1:0]);
               errors++;
            end
         end
      endcase
   endtask

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------
   initial begin
      rst        = 1'b1;
      stb        = 1'b0;
      we         = 1'b0;
      adr        = '0;
      wdat       = '0;
      sample_stb = 1'b0;
      antenna    = '0;
      lfsr_state = 16'd6;   // Seed
      exp_banks  = '0;
      model_prev = '0;      // Matches the DUT history after reset
      errors     = 0;
      checks     = 0;
      for (int k = 0; k < NUM_VIS; k++) begin
         model_acc[k] = 0;
         model_tot[k] = 0;
      end
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      for (int r = 0; r < NUM_ROWS; r++) begin
         err_before = errors;
         run_row(ROWS[r]);
         $display("Row %0d %s: %s", r, row_label(ROWS[r].kind),
                  (errors == err_before) ? "ok" : "FAILED");
      end
      $display("Rows %0d, checks %0d, errors %0d", NUM_ROWS, checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
corr_cfg_pkg.sv
corr_bus_pkg.sv
corr_quadrature.sv
corr_bank_switch.sv
corr_block.sv
corr_regs.sv
corr_bus_decode.sv
corr_top.sv
tb_clock_gen.sv
tb_corr_top.sv

/* Makefile */
# Verilator build and run for the correlator testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_corr_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG)
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Result: PASS"; \
	else \
		echo "Result: FAIL"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
